// File: include/decoder_config.svh
// Widths shared by the RV32 decoder packages, RTL and testbench
// Include after adding include/ to the search path

`ifndef DECODER_CONFIG_SVH
`define DECODER_CONFIG_SVH

`define DEC_XLEN        32  // Data word width
`define DEC_INSTR_W     32  // Instruction word width
`define DEC_REG_IDX_W   4   // Register index in microcode, 16 registers

// Per-stage microcode widths
`define DEC_RD_UCODE_W  10  // Enable, zero bit, rs1, rs2
`define DEC_EX_UCODE_W  6   // Enable, branch, alternate op, funct3
`define DEC_MA_UCODE_W  5   // Enable, store, funct3
`define DEC_WB_UCODE_W  10  // Enable, one bit, rd, zero pad

`endif

// File: rtl/isa_pkg.sv
// RV32 instruction encoding types shared by the decoder and its testbench
// Opcode values, opcode classes and funct3/funct7 codes

`default_nettype none

package isa_pkg;

    // Major opcodes of the supported base set
    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_OP_IMM = 7'b0010011,
        OPC_AUIPC  = 7'b0010111,
        OPC_STORE  = 7'b0100011,
        OPC_OP     = 7'b0110011,
        OPC_LUI    = 7'b0110111,
        OPC_BRANCH = 7'b1100011,
        OPC_JALR   = 7'b1100111,
        OPC_JAL    = 7'b1101111
    } opcode_e;

    typedef enum logic [3:0] {
        CLASS_INVALID = 4'd0,
        CLASS_OP,
        CLASS_OP_IMM,
        CLASS_LOAD,
        CLASS_STORE,
        CLASS_AUIPC,
        CLASS_BRANCH,
        CLASS_JAL,
        CLASS_JALR,
        CLASS_LUI
    } op_class_e;

    typedef enum logic [2:0] {
        F3_ADD_SUB = 3'd0,
        F3_SLL     = 3'd1,
        F3_SLT     = 3'd2,
        F3_SLTU    = 3'd3,
        F3_XOR     = 3'd4,
        F3_SRL_SRA = 3'd5,
        F3_OR      = 3'd6,
        F3_AND     = 3'd7
    } funct3_e;

    // Branch conditions and memory widths share the same funct3 values
    localparam funct3_e F3_BEQ  = F3_ADD_SUB;
    localparam funct3_e F3_BNE  = F3_SLL;
    localparam funct3_e F3_BLT  = F3_XOR;
    localparam funct3_e F3_BGE  = F3_SRL_SRA;
    localparam funct3_e F3_BLTU = F3_OR;
    localparam funct3_e F3_BGEU = F3_AND;
    localparam funct3_e F3_B    = F3_ADD_SUB;
    localparam funct3_e F3_H    = F3_SLL;
    localparam funct3_e F3_W    = F3_SLT;
    localparam funct3_e F3_BU   = F3_XOR;
    localparam funct3_e F3_HU   = F3_SRL_SRA;
    localparam funct3_e F3_JALR = F3_ADD_SUB;

    localparam logic [6:0] F7_ALT = 7'b0100000;  // SUB and SRA select bit

endpackage

`default_nettype wire

// File: rtl/uop_pkg.sv
// Control types driven by the decoder toward the execution pipeline
// Operand mux selects, write-back source and program counter update kind

`default_nettype none

package uop_pkg;

    // Write-back data source
    typedef enum logic [1:0] {
        WB_ALU = 2'd0,
        WB_IMM = 2'd1,
        WB_MEM = 2'd2,
        WB_NPC = 2'd3
    } wb_sel_e;

    // Next program counter
    typedef enum logic [1:0] {
        PC_NPC        = 2'd0,
        PC_REG_TARGET = 2'd1,  // (rs1 + imm) with bit 0 cleared
        PC_REL        = 2'd2,  // pc + imm
        PC_COND_REL   = 2'd3   // Taken branch gives pc + imm, else npc
    } pc_sel_e;

    typedef enum logic {
        ALU_A_RS1 = 1'b0,
        ALU_A_PC  = 1'b1
    } alu_a_sel_e;

    typedef enum logic {
        ALU_B_RS2 = 1'b0,
        ALU_B_IMM = 1'b1
    } alu_b_sel_e;

endpackage

`default_nettype wire

// File: rtl/opcode_classify.sv
// Combinational opcode classifier for the RV32 decoder
// Exact match of the seven opcode bits, anything else is invalid

`timescale 1ns/100ps
`default_nettype none

module opcode_classify
    import isa_pkg::*;
(
    input  wire [6:0] instr_opcode,
    output op_class_e op_class
);

    always_comb begin
        case (instr_opcode)
            OPC_OP: begin
                op_class = CLASS_OP;
            end
            OPC_OP_IMM: begin
                op_class = CLASS_OP_IMM;
            end
            OPC_LOAD: begin
                op_class = CLASS_LOAD;
            end
            OPC_STORE: begin
                op_class = CLASS_STORE;
            end
            OPC_AUIPC: begin
                op_class = CLASS_AUIPC;
            end
            OPC_BRANCH: begin
                op_class = CLASS_BRANCH;
            end
            OPC_JAL: begin
                op_class = CLASS_JAL;
            end
            OPC_JALR: begin
                op_class = CLASS_JALR;
            end
            OPC_LUI: begin
                op_class = CLASS_LUI;
            end
            default: begin
                op_class = CLASS_INVALID;  // FENCE, SYSTEM and unknown
            end
        endcase
    end

endmodule

`default_nettype wire

// File: rtl/fault_detect.sv
// Registered fault flag of the RV32 decoder
// Flags invalid opcodes, registers above x15 and illegal funct3/funct7 fields

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module fault_detect
    import isa_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`DEC_INSTR_W-1:0] instr,
    input  wire op_class_e         op_class,
    output logic                   fault
);

    logic [4:0] rd_idx;
    logic [4:0] rs1_idx;
    logic [4:0] rs2_idx;
    funct3_e    funct3;
    logic [6:0] funct7;
    logic       uses_rs1;
    logic       uses_rs2;
    logic       uses_rd;
    logic       bad_reg;
    logic       bad_funct3;
    logic       bad_funct7;

    assign rd_idx  = instr[11:7];
    assign rs1_idx = instr[19:15];
    assign rs2_idx = instr[24:20];
    assign funct3  = funct3_e'(instr[14:12]);
    assign funct7  = instr[31:25];

    assign uses_rs1 = !(op_class inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL});
    assign uses_rs2 = op_class inside {CLASS_OP, CLASS_STORE, CLASS_BRANCH};
    assign uses_rd  = !(op_class inside {CLASS_STORE, CLASS_BRANCH});

    // Only x0..x15 exist
    assign bad_reg = (uses_rs1 & rs1_idx[4]) | (uses_rs2 & rs2_idx[4]) | (uses_rd & rd_idx[4]);

    always_comb begin
        bad_funct3 = 1'b0;
        bad_funct7 = 1'b0;
        case (op_class)
            CLASS_JALR: begin
                bad_funct3 = (funct3 != F3_JALR);
            end
            CLASS_STORE: begin
                bad_funct3 = !(funct3 inside {F3_B, F3_H, F3_W});
            end
            CLASS_LOAD: begin
                bad_funct3 = !(funct3 inside {F3_B, F3_H, F3_W, F3_BU, F3_HU});
            end
            CLASS_BRANCH: begin
                bad_funct3 = !(funct3 inside {F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU});
            end
            CLASS_OP: begin
                bad_funct7 = ((funct7 & ~F7_ALT) != 7'd0) |
                             (funct7[5] & !(funct3 inside {F3_ADD_SUB, F3_SRL_SRA}));
            end
            CLASS_OP_IMM: begin
                if (funct3 == F3_SLL) begin
                    bad_funct7 = (funct7 != 7'd0);
                end else if (funct3 == F3_SRL_SRA) begin
                    bad_funct7 = ((funct7 & ~F7_ALT) != 7'd0);  // SRAI allowed
                end
            end
            default: begin
                bad_funct3 = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fault <= 1'b0;
        end else begin
            fault <= (op_class == CLASS_INVALID) | bad_reg | bad_funct3 | bad_funct7;
        end
    end

endmodule

`default_nettype wire

// File: rtl/imm_gen.sv
// Immediate generator of the RV32 decoder
// Picks the U, J, B, S or I format by class and registers the
// sign-extended result

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module imm_gen
    import isa_pkg::*;
(
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`DEC_INSTR_W-1:0] instr,
    input  wire op_class_e         op_class,
    output logic [`DEC_XLEN-1:0]   imm
);

    logic [`DEC_XLEN-1:0] imm_next;
    logic                 sign;

    assign sign = instr[31];

    always_comb begin
        case (op_class)
            CLASS_LUI, CLASS_AUIPC: begin
                imm_next = {instr[31:12], 12'd0};
            end
            CLASS_JAL: begin
                imm_next = {{(`DEC_XLEN-20){sign}}, instr[19:12], instr[20],
                            instr[30:21], 1'b0};
            end
            CLASS_BRANCH: begin
                imm_next = {{(`DEC_XLEN-12){sign}}, instr[7], instr[30:25],
                            instr[11:8], 1'b0};
            end
            CLASS_STORE: begin
                imm_next = {{(`DEC_XLEN-11){sign}}, instr[30:25], instr[11:7]};
            end
            default: begin
                imm_next = {{(`DEC_XLEN-11){sign}}, instr[30:20]};  // I-type
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            imm <= '0;
        end else begin
            imm <= imm_next;
        end
    end

endmodule

`default_nettype wire

// File: rtl/stage_control.sv
// Stage control of the RV32 decoder
// Registers the ALU operand selects, write-back source, PC update kind
// and the read, execute, memory and write-back microcode words

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module stage_control
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`DEC_INSTR_W-1:0]     instr,
    input  wire op_class_e             op_class,
    output alu_a_sel_e                 alu_a_sel,
    output alu_b_sel_e                 alu_b_sel,
    output wb_sel_e                    wb_sel,
    output logic [`DEC_RD_UCODE_W-1:0] rd_rf_microcode,
    output logic [`DEC_EX_UCODE_W-1:0] ex_alu_microcode,
    output logic [`DEC_MA_UCODE_W-1:0] ma_mem_microcode,
    output logic [`DEC_WB_UCODE_W-1:0] wb_rf_microcode,
    output pc_sel_e                    pc_sel
);

    funct3_e    funct3;
    logic       rd_en;
    logic       ex_en;
    logic       ma_en;
    logic       wb_en;
    logic       alt_op;
    logic [2:0] ex_funct3;
    wb_sel_e    wb_sel_next;
    pc_sel_e    pc_sel_next;

    assign funct3 = funct3_e'(instr[14:12]);

    assign rd_en = !(op_class inside {CLASS_LUI, CLASS_AUIPC, CLASS_JAL});
    assign ex_en = op_class inside {CLASS_OP, CLASS_OP_IMM, CLASS_BRANCH, CLASS_LOAD,
                                    CLASS_STORE, CLASS_AUIPC, CLASS_JALR};
    assign ma_en = op_class inside {CLASS_LOAD, CLASS_STORE};
    assign wb_en = !(op_class inside {CLASS_STORE, CLASS_BRANCH});

    // SUB and SRA, SRAI
    assign alt_op = instr[30] &
                    (((op_class == CLASS_OP) & (funct3 inside {F3_ADD_SUB, F3_SRL_SRA})) |
                     ((op_class == CLASS_OP_IMM) & (funct3 == F3_SRL_SRA)));

    assign ex_funct3 = (op_class inside {CLASS_OP, CLASS_OP_IMM, CLASS_BRANCH}) ?
                       instr[14:12] : 3'd0;

    always_comb begin
        wb_sel_next = WB_ALU;
        pc_sel_next = PC_NPC;
        case (op_class)
            CLASS_LUI: begin
                wb_sel_next = WB_IMM;
            end
            CLASS_LOAD: begin
                wb_sel_next = WB_MEM;
            end
            CLASS_JAL: begin
                wb_sel_next = WB_NPC;
                pc_sel_next = PC_REL;
            end
            CLASS_JALR: begin
                wb_sel_next = WB_NPC;
                pc_sel_next = PC_REG_TARGET;
            end
            CLASS_BRANCH: begin
                pc_sel_next = PC_COND_REL;
            end
            default: begin
                wb_sel_next = WB_ALU;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            alu_a_sel        <= ALU_A_RS1;
            alu_b_sel        <= ALU_B_RS2;
            wb_sel           <= WB_ALU;
            pc_sel           <= PC_NPC;
            rd_rf_microcode  <= '0;
            ex_alu_microcode <= '0;
            ma_mem_microcode <= '0;
            wb_rf_microcode  <= '0;
        end else begin
            alu_a_sel <= (op_class == CLASS_AUIPC) ? ALU_A_PC : ALU_A_RS1;
            alu_b_sel <= (op_class inside {CLASS_OP, CLASS_BRANCH}) ? ALU_B_RS2 : ALU_B_IMM;
            wb_sel    <= wb_sel_next;
            pc_sel    <= pc_sel_next;
            rd_rf_microcode  <= {rd_en, 1'b0, instr[15 +: `DEC_REG_IDX_W],
                                 instr[20 +: `DEC_REG_IDX_W]};
            ex_alu_microcode <= {ex_en, op_class == CLASS_BRANCH, alt_op, ex_funct3};
            ma_mem_microcode <= {ma_en, op_class == CLASS_STORE, instr[14:12]};
            wb_rf_microcode  <= {wb_en, 1'b1, instr[7 +: `DEC_REG_IDX_W],
                                 {`DEC_REG_IDX_W{1'b0}}};
        end
    end

endmodule

`default_nettype wire

// File: rtl/instruction_decode.sv
// Top of the one-cycle RV32 instruction decoder, 16-register variant
// Takes one instruction per clock, all outputs are valid one cycle later

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module instruction_decode
    import isa_pkg::*;
    import uop_pkg::*;
(
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`DEC_INSTR_W-1:0]     instr,
    output logic [`DEC_XLEN-1:0]       imm,
    output alu_a_sel_e                 alu_a_sel,
    output alu_b_sel_e                 alu_b_sel,
    output wb_sel_e                    wb_sel,
    output logic [`DEC_RD_UCODE_W-1:0] rd_rf_microcode,
    output logic [`DEC_EX_UCODE_W-1:0] ex_alu_microcode,
    output logic [`DEC_MA_UCODE_W-1:0] ma_mem_microcode,
    output logic [`DEC_WB_UCODE_W-1:0] wb_rf_microcode,
    output pc_sel_e                    pc_sel,
    output logic                       fault
);

    op_class_e op_class;  // Combinational, shared by all decoders

    opcode_classify u_classify (
        .instr_opcode (instr[6:0]),
        .op_class     (op_class)
    );

    fault_detect u_fault (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .op_class (op_class),
        .fault    (fault)
    );

    imm_gen u_imm (
        .clk      (clk),
        .reset    (reset),
        .instr    (instr),
        .op_class (op_class),
        .imm      (imm)
    );

    stage_control u_stage (
        .clk              (clk),
        .reset            (reset),
        .instr            (instr),
        .op_class         (op_class),
        .alu_a_sel        (alu_a_sel),
        .alu_b_sel        (alu_b_sel),
        .wb_sel           (wb_sel),
        .rd_rf_microcode  (rd_rf_microcode),
        .ex_alu_microcode (ex_alu_microcode),
        .ma_mem_microcode (ma_mem_microcode),
        .wb_rf_microcode  (wb_rf_microcode),
        .pc_sel           (pc_sel)
    );

endmodule

`default_nettype wire

// File: sim/decode_checker.sv
// Concurrent assertions on the RV32 decoder outputs
// Bound to instruction_decode, counts failures for the testbench to read

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module decode_checker
    import isa_pkg::*;
    import uop_pkg::*;
(
    input wire                        clk,
    input wire                        reset,
    input wire [`DEC_INSTR_W-1:0]     instr,
    input wire                        fault,
    input wire alu_a_sel_e            alu_a_sel,
    input wire alu_b_sel_e            alu_b_sel,
    input wire wb_sel_e               wb_sel,
    input wire pc_sel_e               pc_sel,
    input wire [`DEC_RD_UCODE_W-1:0]  rd_rf_microcode,
    input wire [`DEC_EX_UCODE_W-1:0]  ex_alu_microcode,
    input wire [`DEC_MA_UCODE_W-1:0]  ma_mem_microcode,
    input wire [`DEC_WB_UCODE_W-1:0]  wb_rf_microcode
);

    int fail_count = 0;

    logic rd_en;
    logic ex_en;
    logic ex_branch;
    logic ma_en;
    logic wb_en;

    assign rd_en     = rd_rf_microcode[`DEC_RD_UCODE_W-1];
    assign ex_en     = ex_alu_microcode[`DEC_EX_UCODE_W-1];
    assign ex_branch = ex_alu_microcode[`DEC_EX_UCODE_W-2];
    assign ma_en     = ma_mem_microcode[`DEC_MA_UCODE_W-1];
    assign wb_en     = wb_rf_microcode[`DEC_WB_UCODE_W-1];

    reset_clear: assert property (@(posedge clk)
        $fell(reset) |-> (!fault && !rd_en && !ex_en && !ma_en && !wb_en &&
                          alu_a_sel == ALU_A_RS1 && alu_b_sel == ALU_B_RS2 &&
                          wb_sel == WB_ALU && pc_sel == PC_NPC))
    else begin
        fail_count++;
        $error("outputs not cleared in the cycle after reset");
    end

    lui_no_read: assert property (@(posedge clk) disable iff (reset)
        ($past(instr[6:0]) == OPC_LUI && !fault) |-> (!rd_en && !ex_en && !ma_en))
    else begin
        fail_count++;
        $error("LUI with read, execute or memory stage enabled");
    end

    mem_needs_ex: assert property (@(posedge clk) disable iff (reset)
        ma_en |-> ex_en)
    else begin
        fail_count++;
        $error("memory stage enabled without execute stage");
    end

    cond_rel_branch: assert property (@(posedge clk) disable iff (reset)
        (pc_sel == PC_COND_REL) |-> ex_branch)
    else begin
        fail_count++;
        $error("conditional PC update without branch flag");
    end

endmodule

bind instruction_decode decode_checker u_checker (
    .clk              (clk),
    .reset            (reset),
    .instr            (instr),
    .fault            (fault),
    .alu_a_sel        (alu_a_sel),
    .alu_b_sel        (alu_b_sel),
    .wb_sel           (wb_sel),
    .pc_sel           (pc_sel),
    .rd_rf_microcode  (rd_rf_microcode),
    .ex_alu_microcode (ex_alu_microcode),
    .ma_mem_microcode (ma_mem_microcode),
    .wb_rf_microcode  (wb_rf_microcode)
);

`default_nettype wire

// File: sim/decode_tb.sv
// Table-driven testbench for the RV32 instruction decoder
// Applies one instruction per cycle and checks every output one cycle later

`timescale 1ns/100ps
`default_nettype none
`include "decoder_config.svh"

module decode_tb
    import uop_pkg::*;
();

    localparam int NUM_CASES     = 21;
    localparam int RESET_CYCLES  = 8;
    localparam int RESET_TIMEOUT = 16;

    logic                        clk;
    logic                        reset;
    logic [`DEC_INSTR_W-1:0]     instr;
    logic [`DEC_XLEN-1:0]        imm;
    alu_a_sel_e                  alu_a_sel;
    alu_b_sel_e                  alu_b_sel;
    wb_sel_e                     wb_sel;
    pc_sel_e                     pc_sel;
    logic [`DEC_RD_UCODE_W-1:0]  rd_rf_microcode;
    logic [`DEC_EX_UCODE_W-1:0]  ex_alu_microcode;
    logic [`DEC_MA_UCODE_W-1:0]  ma_mem_microcode;
    logic [`DEC_WB_UCODE_W-1:0]  wb_rf_microcode;
    logic                        fault;

    string                       t_name  [NUM_CASES];
    logic [`DEC_INSTR_W-1:0]     t_instr [NUM_CASES];
    logic [`DEC_XLEN-1:0]        t_imm   [NUM_CASES];
    logic                        t_fault [NUM_CASES];
    alu_a_sel_e                  t_a     [NUM_CASES];
    alu_b_sel_e                  t_b     [NUM_CASES];
    wb_sel_e                     t_wb    [NUM_CASES];
    pc_sel_e                     t_pc    [NUM_CASES];
    logic [`DEC_RD_UCODE_W-1:0]  t_rd    [NUM_CASES];
    logic [`DEC_EX_UCODE_W-1:0]  t_ex    [NUM_CASES];
    logic [`DEC_MA_UCODE_W-1:0]  t_ma    [NUM_CASES];
    logic [`DEC_WB_UCODE_W-1:0]  t_wbu   [NUM_CASES];
    int                          n_cases = 0;

    instruction_decode UUT (
        .clk              (clk),
        .reset            (reset),
        .instr            (instr),
        .imm              (imm),
        .alu_a_sel        (alu_a_sel),
        .alu_b_sel        (alu_b_sel),
        .wb_sel           (wb_sel),
        .rd_rf_microcode  (rd_rf_microcode),
        .ex_alu_microcode (ex_alu_microcode),
        .ma_mem_microcode (ma_mem_microcode),
        .wb_rf_microcode  (wb_rf_microcode),
        .pc_sel           (pc_sel),
        .fault            (fault)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic stop_on_failure();
        $display("TB FAILED");
        $fatal(1, "simulation stopped at first error");
    endtask

    task automatic report_mismatch(input string name, input string what,
                                   input logic [31:0] exp, input logic [31:0] act);
        $display("ERR %s %s expected %0h actual %0h", name, what, exp, act);
        stop_on_failure();
    endtask

    task automatic check_word(input string name, input logic [`DEC_XLEN-1:0] exp,
                              input logic [`DEC_XLEN-1:0] act);
        if (act !== exp) report_mismatch(name, "imm", exp, act);
    endtask

    task automatic check_fault(input string name, input logic exp, input logic act);
        if (act !== exp) report_mismatch(name, "fault", exp, act);
    endtask

    task automatic check_wb_sel(input string name, input wb_sel_e exp, input wb_sel_e act);
        if (act !== exp) report_mismatch(name, "wb_sel", exp, act);
    endtask

    task automatic check_pc_sel(input string name, input pc_sel_e exp, input pc_sel_e act);
        if (act !== exp) report_mismatch(name, "pc_sel", exp, act);
    endtask

    task automatic check_alu_a_sel(input string name, input alu_a_sel_e exp,
                                   input alu_a_sel_e act);
        if (act !== exp) report_mismatch(name, "alu_a_sel", exp, act);
    endtask

    task automatic check_alu_b_sel(input string name, input alu_b_sel_e exp,
                                   input alu_b_sel_e act);
        if (act !== exp) report_mismatch(name, "alu_b_sel", exp, act);
    endtask

    // Widest microcode word, narrower ones are zero-extended
    task automatic check_ucode(input string name, input string what,
                               input logic [`DEC_RD_UCODE_W-1:0] exp,
                               input logic [`DEC_RD_UCODE_W-1:0] act);
        if (act !== exp) report_mismatch(name, what, exp, act);
    endtask

    task automatic check_outputs(input string name, input logic [31:0] e_imm, input logic e_fault,
                                 input alu_a_sel_e e_a, input alu_b_sel_e e_b,
                                 input wb_sel_e e_wb, input pc_sel_e e_pc,
                                 input logic [9:0] e_rd, input logic [5:0] e_ex,
                                 input logic [4:0] e_ma, input logic [9:0] e_wbu);
        check_word(name, e_imm, imm);
        check_fault(name, e_fault, fault);
        check_alu_a_sel(name, e_a, alu_a_sel);
        check_alu_b_sel(name, e_b, alu_b_sel);
        check_wb_sel(name, e_wb, wb_sel);
        check_pc_sel(name, e_pc, pc_sel);
        check_ucode(name, "rd_rf_microcode", e_rd, rd_rf_microcode);
        check_ucode(name, "ex_alu_microcode", e_ex, ex_alu_microcode);
        check_ucode(name, "ma_mem_microcode", e_ma, ma_mem_microcode);
        check_ucode(name, "wb_rf_microcode", e_wbu, wb_rf_microcode);
        if (UUT.u_checker.fail_count != 0) begin
            $display("Assertion in the bound checker failed during %s", name);
            stop_on_failure();
        end
    endtask

    task automatic add_case(input string name, input logic [31:0] i_word, input logic [31:0] e_imm,
                            input logic e_fault, input alu_a_sel_e e_a, input alu_b_sel_e e_b,
                            input wb_sel_e e_wb, input pc_sel_e e_pc, input logic [9:0] e_rd,
                            input logic [5:0] e_ex, input logic [4:0] e_ma,
                            input logic [9:0] e_wbu);
        t_name[n_cases]  = name;
        t_instr[n_cases] = i_word;
        t_imm[n_cases]   = e_imm;
        t_fault[n_cases] = e_fault;
        t_a[n_cases]     = e_a;
        t_b[n_cases]     = e_b;
        t_wb[n_cases]    = e_wb;
        t_pc[n_cases]    = e_pc;
        t_rd[n_cases]    = e_rd;
        t_ex[n_cases]    = e_ex;
        t_ma[n_cases]    = e_ma;
        t_wbu[n_cases]   = e_wbu;
        n_cases++;
    endtask

    // Microcode: rd {en,0,rs1,rs2}, ex {en,br,alt,f3}, ma {en,st,f3}, wb {en,1,rd,0}
    task automatic fill_table();
        add_case("lui", 32'habcde2b7, 32'habcde000, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_IMM, PC_NPC, 10'h0bc, 6'h00, 5'h06, 10'h350);
        add_case("auipc", 32'h00001197, 32'h00001000, 1'b0,
                 ALU_A_PC, ALU_B_IMM, WB_ALU, PC_NPC, 10'h000, 6'h20, 5'h01, 10'h330);
        add_case("jal_neg", 32'hff9ff0ef, 32'hfffffff8, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_NPC, PC_REL, 10'h0f9, 6'h00, 5'h07, 10'h310);
        add_case("jalr", 32'h004100e7, 32'h00000004, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_NPC, PC_REG_TARGET, 10'h224, 6'h20, 5'h00, 10'h310);
        add_case("bne_neg", 32'hfe4198e3, 32'hfffffff0, 1'b0,
                 ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_COND_REL, 10'h234, 6'h31, 5'h01, 10'h110);
        add_case("lw_neg", 32'hffc32283, 32'hfffffffc, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_MEM, PC_NPC, 10'h26c, 6'h20, 5'h12, 10'h350);
        add_case("sw_neg", 32'hfe742a23, 32'hfffffff4, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h287, 6'h20, 5'h1a, 10'h140);
        add_case("sub_alt", 32'h40b504b3, 32'h0000040b, 1'b0,
                 ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_NPC, 10'h2ab, 6'h28, 5'h00, 10'h390);
        add_case("addi_neg", 32'hffb10093, 32'hfffffffb, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h22b, 6'h20, 5'h00, 10'h310);
        add_case("addi_rd_x16", 32'h00108813, 32'h00000001, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h211, 6'h20, 5'h00, 10'h300);
        add_case("sw_rs2_x17", 32'h0110a023, 32'h00000000, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h211, 6'h20, 5'h1a, 10'h100);
        add_case("jalr_rs1_x20", 32'h000a00e7, 32'h00000000, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_NPC, PC_REG_TARGET, 10'h240, 6'h20, 5'h00, 10'h310);
        add_case("beq_rd_x31", 32'h00208fe3, 32'h0000081e, 1'b0,
                 ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_COND_REL, 10'h212, 6'h30, 5'h00, 10'h1f0);
        add_case("load_f3_3", 32'h0000b103, 32'h00000000, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_MEM, PC_NPC, 10'h210, 6'h20, 5'h13, 10'h320);
        add_case("branch_f3_2", 32'h0020a063, 32'h00000000, 1'b1,
                 ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_COND_REL, 10'h212, 6'h32, 5'h02, 10'h100);
        add_case("xor_f7_alt", 32'h4020c1b3, 32'h00000402, 1'b1,
                 ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_NPC, 10'h212, 6'h24, 5'h04, 10'h330);
        add_case("slli_f7", 32'h02209193, 32'h00000022, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h212, 6'h21, 5'h01, 10'h330);
        add_case("srai_alt", 32'h4032d213, 32'h00000403, 1'b0,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h253, 6'h2d, 5'h05, 10'h340);
        add_case("fence", 32'h0ff0000f, 32'h000000ff, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h20f, 6'h00, 5'h00, 10'h300);
        add_case("all_zero", 32'h00000000, 32'h00000000, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h200, 6'h00, 5'h00, 10'h300);
        add_case("opc_low_00", 32'h00108090, 32'h00000001, 1'b1,
                 ALU_A_RS1, ALU_B_IMM, WB_ALU, PC_NPC, 10'h211, 6'h00, 5'h00, 10'h310);
    endtask

    initial begin
        int cycles;
        reset = 1'b1;
        instr = '0;
        fill_table();
        cycles = 0;
        while (cycles < RESET_CYCLES || fault !== 1'b0) begin  // Hold reset, wait for clear
            @(negedge clk);
            cycles++;
            if (cycles > RESET_TIMEOUT) begin
                $display("Timeout: fault flag did not clear during reset");
                stop_on_failure();
            end
        end
        check_outputs("reset", '0, 1'b0, ALU_A_RS1, ALU_B_RS2, WB_ALU, PC_NPC,
                      10'h000, 6'h00, 5'h00, 10'h000);
        reset = 1'b0;
        instr = t_instr[0];
        for (int i = 1; i <= n_cases; i++) begin  // Next case goes in as the last comes out
            @(negedge clk);
            check_outputs(t_name[i-1], t_imm[i-1], t_fault[i-1], t_a[i-1], t_b[i-1],
                          t_wb[i-1], t_pc[i-1], t_rd[i-1], t_ex[i-1], t_ma[i-1], t_wbu[i-1]);
            if (i < n_cases) begin
                instr = t_instr[i];
            end
        end
        @(negedge clk);  // One more edge for the checker on the last outputs
        if (UUT.u_checker.fail_count != 0 || n_cases != NUM_CASES) begin
            $display("Checker errors or incomplete case table at end of run");
            stop_on_failure();
        end else begin
            $display("TB PASSED");
            $finish;
        end
    end

endmodule

`default_nettype wire

// File: sim.f
+incdir+include
rtl/isa_pkg.sv
rtl/uop_pkg.sv
rtl/opcode_classify.sv
rtl/fault_detect.sv
rtl/imm_gen.sv
rtl/stage_control.sv
rtl/instruction_decode.sv
sim/decode_checker.sv
sim/decode_tb.sv
